/* list.f */
+incdir+verilog
verilog/stq_core_pkg.sv
verilog/stq_mem_pkg.sv
verilog/stq_entry.sv
verilog/stq_alloc.sv
verilog/stq_drain.sv
verilog/stq_top.sv
verif/tb_clk_gen.sv
verif/tb_stq.sv

/* run_sim.sh */
#!/bin/sh
# Build the store queue testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module tb_stq -Mdir "$BUILD_DIR" -o tb_stq
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_stq" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
  exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

/* verif/tb_clk_gen.sv */
// Testbench clock and power-on reset source for the store queue testbench
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 8
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(period_ns / 2) o_clk = ~o_clk;
  end

  // Release away from the rising edge
  initial begin
    o_reset_n = 1'b0;
    repeat (reset_cycles) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

/* verif/tb_stq.sv */
// Directed testbench for the store queue top level and built through list.f with Verilator
`timescale 1ns/10ps
`include "stq_consts.svh"

module tb_stq;

  localparam int clk_period_ns = 8;
  localparam int drain_limit   = 200;
  // Cycle budget of the tests in run order
  localparam int test_cycles   = 20 + 60 + 200 + 80 + 400 + 200;
  localparam int wd_margin     = 4;
  localparam int watchdog_ns   = test_cycles * wd_margin * clk_period_ns;

  logic                          clk;
  logic                          reset_n;
  logic                          disp_valid;
  stq_core_pkg::disp_t           disp;
  logic                          disp_ready;
  stq_core_pkg::stq_idx_t        disp_idx;
  logic                          ex1_valid;
  stq_mem_pkg::ex1_upd_t         ex1;
  logic                          data_valid;
  stq_mem_pkg::data_wr_t         data_wr;
  logic                          commit_valid;
  stq_core_pkg::cmt_id_t         commit_id;
  stq_core_pkg::flush_t          flush;
  logic                          req_valid;
  stq_mem_pkg::stbuf_req_t       req;
  logic                          accept;
  logic                          empty;

  // Reference model of the queue
  stq_mem_pkg::stbuf_req_t       exp_q [$];
  stq_core_pkg::stq_idx_t        exp_tail;
  stq_core_pkg::cmt_id_t         next_id;

  int                            n_errors;
  int                            n_checks;
  int                            n_tests;
  int                            n_xfers;
  int                            test_errs;
  string                         cur_test;
  logic                          bp_mode;
  logic                          prev_wait = 1'b0;
  stq_mem_pkg::stbuf_req_t       prev_req = '0;

  tb_clk_gen #(.period_ns(clk_period_ns), .reset_cycles(8)) clk_gen_i (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  stq_top dut_i (
    .i_clk             (clk),
    .i_reset_n         (reset_n),
    .i_disp_valid      (disp_valid),
    .i_disp            (disp),
    .o_disp_ready      (disp_ready),
    .o_disp_idx        (disp_idx),
    .i_ex1_valid       (ex1_valid),
    .i_ex1             (ex1),
    .i_data_valid      (data_valid),
    .i_data            (data_wr),
    .i_commit_valid    (commit_valid),
    .i_commit_cmt_id   (commit_id),
    .i_flush           (flush),
    .o_stbuf_req_valid (req_valid),
    .o_stbuf_req       (req),
    .i_stbuf_accept    (accept),
    .o_empty           (empty)
  );

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------

  task automatic check_req(input string name, input stq_mem_pkg::stbuf_req_t exp,
                           input stq_mem_pkg::stbuf_req_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_idx(input string name, input stq_core_pkg::stq_idx_t exp,
                           input stq_core_pkg::stq_idx_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_xfers(input string name, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
      n_errors++;
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------

  function automatic stq_mem_pkg::stbuf_req_t rand_store();
    stq_mem_pkg::stbuf_req_t s;
    logic [63:0]             r64;
    r64 = {$urandom(), $urandom()};
    s.paddr    = r64[`PADDR_W-1:0];
    s.uncached = r64[50];
    s.size     = stq_mem_pkg::size_t'($urandom_range(0, 3));
    r64 = {$urandom(), $urandom()};
    s.data = r64;
    return s;
  endfunction

  task automatic clear_strobes();
    disp_valid   <= 1'b0;
    ex1_valid    <= 1'b0;
    data_valid   <= 1'b0;
    commit_valid <= 1'b0;
    flush.valid  <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      clear_strobes();
    end
    @(negedge clk);
  endtask

  task automatic dispatch_store(output stq_core_pkg::stq_idx_t idx,
                                output stq_core_pkg::cmt_id_t id);
    @(posedge clk);
    clear_strobes();
    disp_valid  <= 1'b1;
    disp.cmt_id <= next_id;
    @(negedge clk);
    check_bit({cur_test, " disp_ready"}, 1'b1, disp_ready);
    check_idx({cur_test, " disp_idx"}, exp_tail, disp_idx);
    idx = exp_tail;
    id  = next_id;
    exp_tail++;
    next_id++;
  endtask

  task automatic send_address(input stq_core_pkg::stq_idx_t idx,
                              input stq_mem_pkg::stbuf_req_t s, input logic miss);
    stq_mem_pkg::ex1_upd_t u;
    u.idx      = idx;
    u.paddr    = s.paddr;
    u.size     = s.size;
    u.tlb_miss = miss;
    u.uncached = s.uncached;
    @(posedge clk);
    clear_strobes();
    ex1_valid <= 1'b1;
    ex1       <= u;
    @(negedge clk);
  endtask

  task automatic write_data(input stq_core_pkg::stq_idx_t idx, input logic [`DATA_W-1:0] d);
    stq_mem_pkg::data_wr_t w;
    w.idx  = idx;
    w.data = d;
    @(posedge clk);
    clear_strobes();
    data_valid <= 1'b1;
    data_wr    <= w;
    @(negedge clk);
  endtask

  task automatic commit_store(input stq_core_pkg::cmt_id_t id);
    @(posedge clk);
    clear_strobes();
    commit_valid <= 1'b1;
    commit_id    <= id;
    @(negedge clk);
  endtask

  task automatic flush_from(input stq_core_pkg::cmt_id_t id);
    stq_core_pkg::flush_t f;
    f.valid  = 1'b1;
    f.cmt_id = id;
    @(posedge clk);
    clear_strobes();
    flush <= f;
    @(negedge clk);
  endtask

  // Idle until the queue reports empty and count the transfers
  task automatic wait_drain(input int xfers_before, input int expected);
    int cyc;
    cyc = 0;
    while (!empty && cyc < drain_limit) begin
      idle(1);
      cyc++;
    end
    if (cyc >= drain_limit) begin
      n_errors++;
      $display("Error %s: queue did not drain within %0d cycles", cur_test, drain_limit);
    end
    check_xfers({cur_test, " transfers"}, expected, n_xfers - xfers_before);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = n_errors;
    n_tests++;
  endtask

  task automatic end_test();
    if (n_errors == test_errs) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, n_errors - test_errs);
    end
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------

  task automatic test_reset();
    start_test("reset");
    check_bit({cur_test, " req_valid"}, 1'b0, req_valid);
    check_bit({cur_test, " disp_ready"}, 1'b1, disp_ready);
    check_bit({cur_test, " empty"}, 1'b1, empty);
    end_test();
  endtask

  task automatic test_one_store();
    stq_core_pkg::stq_idx_t  idx;
    stq_core_pkg::cmt_id_t   id;
    stq_mem_pkg::stbuf_req_t s;
    int                      x0;
    start_test("one_store");
    x0 = n_xfers;
    s  = rand_store();
    dispatch_store(idx, id);
    send_address(idx, s, 1'b0);
    check_bit({cur_test, " empty busy"}, 1'b0, empty);
    write_data(idx, s.data);
    exp_q.push_back(s);
    commit_store(id);
    wait_drain(x0, 1);
    end_test();
  endtask

  task automatic test_order();
    stq_core_pkg::stq_idx_t  idx [5];
    stq_core_pkg::cmt_id_t   id [5];
    stq_mem_pkg::stbuf_req_t st [5];
    int                      ev [15];
    int                      j;
    int                      k;
    int                      tmp;
    int                      x0;
    start_test("order");
    x0 = n_xfers;
    for (int i = 0; i < 5; i++) begin
      st[i] = rand_store();
      dispatch_store(idx[i], id[i]);
      exp_q.push_back(st[i]);
    end
    // Three events per store in shuffled order
    for (int i = 0; i < 15; i++) begin
      ev[i] = i;
    end
    for (int i = 14; i > 0; i--) begin
      j      = int'($urandom_range(0, i));
      tmp    = ev[i];
      ev[i]  = ev[j];
      ev[j]  = tmp;
    end
    for (int i = 0; i < 15; i++) begin
      k = ev[i] / 3;
      case (ev[i] % 3)
        0:       send_address(idx[k], st[k], 1'b0);
        1:       write_data(idx[k], st[k].data);
        default: commit_store(id[k]);
      endcase
    end
    wait_drain(x0, 5);
    end_test();
  endtask

  task automatic test_tlb_replay();
    stq_core_pkg::stq_idx_t  idx;
    stq_core_pkg::cmt_id_t   id;
    stq_mem_pkg::stbuf_req_t s_miss;
    stq_mem_pkg::stbuf_req_t s_hit;
    int                      x0;
    start_test("tlb_replay");
    x0     = n_xfers;
    s_miss = rand_store();
    s_hit  = rand_store();
    dispatch_store(idx, id);
    send_address(idx, s_miss, 1'b1);
    write_data(idx, s_hit.data);
    commit_store(id);
    repeat (6) begin
      idle(1);
      check_bit({cur_test, " no request"}, 1'b0, req_valid);
    end
    exp_q.push_back(s_hit);
    send_address(idx, s_hit, 1'b0);
    wait_drain(x0, 1);
    end_test();
  endtask

  task automatic test_backpressure();
    stq_core_pkg::stq_idx_t  idx;
    stq_core_pkg::cmt_id_t   id;
    stq_mem_pkg::stbuf_req_t s;
    int                      x0;
    start_test("backpressure");
    x0      = n_xfers;
    bp_mode = 1'b1;
    for (int i = 0; i < 6; i++) begin
      s = rand_store();
      dispatch_store(idx, id);
      send_address(idx, s, 1'b0);
      write_data(idx, s.data);
      exp_q.push_back(s);
      commit_store(id);
    end
    wait_drain(x0, 6);
    bp_mode = 1'b0;
    end_test();
  endtask

  task automatic test_full_flush();
    stq_core_pkg::stq_idx_t  idx [8];
    stq_core_pkg::cmt_id_t   id [8];
    stq_mem_pkg::stbuf_req_t s;
    int                      x0;
    start_test("full_flush");
    x0 = n_xfers;
    for (int i = 0; i < 8; i++) begin
      dispatch_store(idx[i], id[i]);
    end
    idle(1);
    check_bit({cur_test, " disp_ready full"}, 1'b0, disp_ready);
    for (int i = 0; i < 2; i++) begin
      s = rand_store();
      send_address(idx[i], s, 1'b0);
      write_data(idx[i], s.data);
      exp_q.push_back(s);
    end
    commit_store(id[0]);
    commit_store(id[1]);
    // Third store and everything younger die
    flush_from(id[2]);
    wait_drain(x0, 2);
    check_bit({cur_test, " disp_ready after"}, 1'b1, disp_ready);
    end_test();
  endtask

  // ----------------------------------------------------------------------
  // Store buffer side
  // ----------------------------------------------------------------------

  // Accept level with random stretches while back-pressure is on
  initial begin
    int   left;
    logic level;
    left   = 0;
    level  = 1'b1;
    accept = 1'b1;
    forever begin
      @(posedge clk);
      if (!bp_mode) begin
        accept <= 1'b1;
      end else begin
        if (left == 0) begin
          level = ($urandom_range(0, 1) == 1);
          left  = int'($urandom_range(1, 6));
        end
        left--;
        accept <= level;
      end
    end
  end

  // Transfer monitor that also checks the request holds while waiting
  always @(negedge clk) begin
    if (reset_n) begin
      if (prev_wait) begin
        check_bit({cur_test, " request held"}, 1'b1, req_valid);
        check_req({cur_test, " request stable"}, prev_req, req);
      end
      if (req_valid && accept) begin
        n_xfers++;
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("Error %s: store buffer request arrived with none expected", cur_test);
        end else begin
          check_req(cur_test, exp_q.pop_front(), req);
        end
      end
      prev_wait = req_valid && !accept;
      prev_req  = req;
    end
  end

  initial begin
    #(watchdog_ns);
    $display("Error: watchdog expired after %0d ns, tests did not finish", watchdog_ns);
    $display("*** FAILED ***");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    void'($urandom(32'h9970));
    disp_valid   = 1'b0;
    disp         = '0;
    ex1_valid    = 1'b0;
    ex1          = '0;
    data_valid   = 1'b0;
    data_wr      = '0;
    commit_valid = 1'b0;
    commit_id    = '0;
    flush        = '0;
    exp_tail     = '0;
    next_id      = '0;
    n_errors     = 0;
    n_checks     = 0;
    n_tests      = 0;
    n_xfers      = 0;
    bp_mode      = 1'b0;
    cur_test     = "reset";

    wait (reset_n == 1'b1);
    @(negedge clk);

    test_reset();
    test_one_store();
    test_order();
    test_tlb_replay();
    test_backpressure();
    test_full_flush();

    $display("Summary: %0d tests, %0d checks, %0d errors, %0d transfers",
             n_tests, n_checks, n_errors, n_xfers);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/stq_alloc.sv */
// Store queue allocation, hands out slots in program order and tracks occupancy
`timescale 1ns/10ps
`include "stq_consts.svh"

module stq_alloc (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  logic                        i_disp_valid,
  input  stq_core_pkg::disp_t         i_disp,

  // From drain
  input  stq_core_pkg::stq_idx_t      i_head,
  input  logic                        i_retire,

  output logic                        o_disp_ready,
  output stq_core_pkg::stq_idx_t      o_disp_idx,
  output logic [`STQ_ENTRIES-1:0]     o_load,
  output stq_core_pkg::disp_t         o_disp,
  output logic                        o_empty
);

  stq_core_pkg::stq_idx_t  r_tail;
  logic [`STQ_IDX_W:0]     r_count;
  logic                    w_alloc;

  assign o_disp_ready = (r_count < `STQ_ENTRIES);
  assign o_empty      = (r_count == '0);
  assign w_alloc      = i_disp_valid & o_disp_ready;

  assign o_disp_idx = r_tail;
  assign o_disp     = i_disp;

  // Tail decoded to a one-hot slot load
  assign o_load = w_alloc ? (`STQ_ENTRIES'(1) << r_tail) : '0;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail  <= '0;
      r_count <= '0;
    end else begin
      if (w_alloc) begin
        r_tail <= r_tail + 1'b1;
      end
      // Allocation and retire together leave the count alone
      case ({w_alloc, i_retire})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  a_count_max : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_count <= `STQ_ENTRIES
  ) else $error("stq_alloc: occupancy overflow");

  a_no_load_full : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (r_count == `STQ_ENTRIES) |-> (o_load == '0)
  ) else $error("stq_alloc: load while full");

  // Head from drain and tail must stay the occupancy apart
  a_ptr_distance : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    stq_core_pkg::stq_idx_t'(r_tail - i_head) == r_count[`STQ_IDX_W-1:0]
  ) else $error("stq_alloc: head/tail out of step with count");

endmodule

/* verilog/stq_consts.svh */
// Store queue sizing constants, included by every package and module of the queue
`ifndef STQ_CONSTS_SVH
`define STQ_CONSTS_SVH

// ----------------------------------------------------------------------
// Queue geometry
// ----------------------------------------------------------------------

// Number of store queue slots, kept a power of two
`define STQ_ENTRIES 8

// Width of a slot index
`define STQ_IDX_W 3

// ----------------------------------------------------------------------
// Field widths
// ----------------------------------------------------------------------

// Commit id, wraps around and is compared by age
`define CMT_ID_W 6

`define PADDR_W 34

`define DATA_W 64

`endif

/* verilog/stq_core_pkg.sv */
// Instruction-side types of the store queue: ids, dispatch payload and flush
`include "stq_consts.svh"

package stq_core_pkg;

  // Commit id handed out at dispatch
  typedef logic [`CMT_ID_W-1:0] cmt_id_t;

  // Store queue slot number
  typedef logic [`STQ_IDX_W-1:0] stq_idx_t;

  // Dispatch payload for one store
  typedef struct packed {
    cmt_id_t cmt_id;
  } disp_t;

  // Branch or exception flush, kills this id and everything younger
  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
  } flush_t;

  // ----------------------------------------------------------------------
  // Age compare on wrapping ids
  // ----------------------------------------------------------------------

  // True when id a is the same age as id b or younger
  function automatic logic is_younger_eq(cmt_id_t a, cmt_id_t b);
    cmt_id_t diff;
    diff = a - b;
    // Distance below half the id space means a is not older
    return ~diff[`CMT_ID_W-1];
  endfunction

endpackage

/* verilog/stq_drain.sv */
// Store queue drain, walks the head slot out to the store buffer and retires it
`timescale 1ns/10ps
`include "stq_consts.svh"

module stq_drain (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  stq_mem_pkg::stq_entry_t     i_entries [`STQ_ENTRIES],
  input  logic [`STQ_ENTRIES-1:0]     i_req_valid,
  input  logic [`STQ_ENTRIES-1:0]     i_finish,

  input  logic                        i_stbuf_accept,

  output logic [`STQ_ENTRIES-1:0]     o_outptr,
  output logic [`STQ_ENTRIES-1:0]     o_accept,
  output stq_core_pkg::stq_idx_t      o_head,
  output logic                        o_retire,

  output logic                        o_stbuf_req_valid,
  output stq_mem_pkg::stbuf_req_t     o_stbuf_req
);

  stq_core_pkg::stq_idx_t   r_head;
  stq_mem_pkg::stq_entry_t  w_head_entry;

  assign o_head       = r_head;
  assign o_outptr     = `STQ_ENTRIES'(1) << r_head;
  assign w_head_entry = i_entries[r_head];

  // ----------------------------------------------------------------------
  // Store buffer request
  // ----------------------------------------------------------------------

  assign o_stbuf_req_valid     = i_req_valid[r_head];
  assign o_stbuf_req.paddr     = w_head_entry.paddr;
  assign o_stbuf_req.size      = w_head_entry.size;
  assign o_stbuf_req.uncached  = w_head_entry.uncached;
  assign o_stbuf_req.data      = w_head_entry.data;

  // Accept only goes back to the head slot
  assign o_accept = i_stbuf_accept ? o_outptr : '0;

  // Head finish frees the slot and moves the pointer on
  assign o_retire = i_finish[r_head];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
    end else if (o_retire) begin
      r_head <= r_head + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // Head slot must not change under a waiting request
  a_req_stable : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (o_stbuf_req_valid && !i_stbuf_accept) |=> (o_stbuf_req_valid && $stable(o_stbuf_req))
  ) else $error("stq_drain: request changed while waiting");

endmodule

/* verilog/stq_entry.sv */
// One store queue slot, collects address, data and commit and then drains from the head
`timescale 1ns/10ps
`include "stq_consts.svh"

module stq_entry #(
  parameter int entry_index = 0
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,

  // Dispatch
  input  logic                       i_load,
  input  stq_core_pkg::disp_t        i_disp,
  input  logic                       i_flush_at_disp,

  // EX1 address result
  input  logic                       i_ex1_valid,
  input  stq_mem_pkg::ex1_upd_t      i_ex1,

  // Store data
  input  logic                       i_data_valid,
  input  stq_mem_pkg::data_wr_t      i_data,

  // Commit and flush
  input  logic                       i_commit_valid,
  input  stq_core_pkg::cmt_id_t      i_commit_cmt_id,
  input  stq_core_pkg::flush_t       i_flush,

  // Drain side
  input  logic                       i_outptr_valid,
  input  logic                       i_stbuf_accept,

  output stq_mem_pkg::stq_entry_t    o_entry,
  output logic                       o_req_valid,
  output logic                       o_finish
);

  localparam logic [`STQ_IDX_W-1:0] local_idx = entry_index[`STQ_IDX_W-1:0];

  stq_mem_pkg::stq_entry_t r_entry;
  stq_mem_pkg::stq_entry_t w_entry_next;

  logic w_ex1_hit;
  logic w_data_hit;
  logic w_commit_hit;
  logic w_flush_hit;
  logic w_load_dead;

  assign o_entry = r_entry;

  // ----------------------------------------------------------------------
  // Update matching
  // ----------------------------------------------------------------------

  assign w_ex1_hit  = i_ex1_valid & (i_ex1.idx == local_idx);
  assign w_data_hit = i_data_valid & (i_data.idx == local_idx);

  assign w_commit_hit = i_commit_valid & r_entry.valid & ~r_entry.dead &
                        (r_entry.cmt_id == i_commit_cmt_id);

  // A commit in the same cycle wins, the entry is older than the flush point
  assign w_flush_hit = i_flush.valid & r_entry.valid & ~r_entry.committed & ~w_commit_hit &
                       stq_core_pkg::is_younger_eq(r_entry.cmt_id, i_flush.cmt_id);

  // Flush racing with dispatch kills the new store right away
  assign w_load_dead = i_flush_at_disp &
                       stq_core_pkg::is_younger_eq(i_disp.cmt_id, i_flush.cmt_id);

  // ----------------------------------------------------------------------
  // Drain outputs
  // ----------------------------------------------------------------------

  assign o_req_valid = i_outptr_valid & r_entry.valid & r_entry.committed & ~r_entry.dead &
                       r_entry.paddr_valid & r_entry.data_got & ~r_entry.stbuf_done;

  assign o_finish = i_outptr_valid & r_entry.valid & (r_entry.stbuf_done | r_entry.dead);

  always_comb begin
    w_entry_next = r_entry;
    if (i_load) begin
      w_entry_next.valid       = 1'b1;
      w_entry_next.cmt_id      = i_disp.cmt_id;
      w_entry_next.paddr_valid = 1'b0;
      w_entry_next.data_got    = 1'b0;
      w_entry_next.committed   = 1'b0;
      w_entry_next.dead        = w_load_dead;
      w_entry_next.stbuf_done  = 1'b0;
    end else if (r_entry.valid) begin
      if (o_finish) begin
        w_entry_next.valid = 1'b0;
      end else begin
        // Only the first good translation sticks, a TLB miss waits for replay
        if (w_ex1_hit & ~r_entry.paddr_valid) begin
          w_entry_next.paddr       = i_ex1.paddr;
          w_entry_next.size        = i_ex1.size;
          w_entry_next.uncached    = i_ex1.uncached;
          w_entry_next.paddr_valid = ~i_ex1.tlb_miss;
        end
        if (w_data_hit) begin
          w_entry_next.data     = i_data.data;
          w_entry_next.data_got = 1'b1;
        end
        if (w_commit_hit) begin
          w_entry_next.committed = 1'b1;
        end
        if (w_flush_hit) begin
          w_entry_next.dead = 1'b1;
        end
        if (o_req_valid & i_stbuf_accept) begin
          w_entry_next.stbuf_done = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_entry.valid       <= 1'b0;
      r_entry.paddr_valid <= 1'b0;
      r_entry.data_got    <= 1'b0;
      r_entry.committed   <= 1'b0;
      r_entry.dead        <= 1'b0;
      r_entry.stbuf_done  <= 1'b0;
    end else begin
      r_entry <= w_entry_next;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // The core only sends address or data for slots it was handed at dispatch
  a_upd_to_valid : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (w_ex1_hit | w_data_hit) |-> r_entry.valid
  ) else $error("stq_entry %0d: update to invalid slot", entry_index);

  a_commit_dead_excl : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_entry.valid |-> !(r_entry.committed && r_entry.dead)
  ) else $error("stq_entry %0d: committed and dead together", entry_index);

endmodule

/* verilog/stq_mem_pkg.sv */
// Memory-side types of the store queue: address update, data write, slot state
`include "stq_consts.svh"

package stq_mem_pkg;

  // Access size of a store
  typedef enum logic [1:0] {
    sz_byte  = 2'd0,
    sz_half  = 2'd1,
    sz_word  = 2'd2,
    sz_dword = 2'd3
  } size_t;

  // Address result from the LSU EX1 stage
  typedef struct packed {
    stq_core_pkg::stq_idx_t idx;
    logic [`PADDR_W-1:0]    paddr;
    size_t                  size;
    logic                   tlb_miss;
    logic                   uncached;
  } ex1_upd_t;

  // Store data delivery, keyed by slot
  typedef struct packed {
    stq_core_pkg::stq_idx_t idx;
    logic [`DATA_W-1:0]     data;
  } data_wr_t;

  // ----------------------------------------------------------------------
  // Slot state
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic                  valid;
    stq_core_pkg::cmt_id_t cmt_id;
    logic                  paddr_valid;
    logic [`PADDR_W-1:0]   paddr;
    size_t                 size;
    logic                  uncached;
    logic                  data_got;
    logic [`DATA_W-1:0]    data;
    logic                  committed;
    logic                  dead;
    logic                  stbuf_done;
  } stq_entry_t;

  // Request to the store buffer, uncached flag rides along
  typedef struct packed {
    logic [`PADDR_W-1:0] paddr;
    size_t               size;
    logic                uncached;
    logic [`DATA_W-1:0]  data;
  } stbuf_req_t;

endpackage

/* verilog/stq_top.sv */
// Store queue top, joins allocation, the slot array and the drain stage
`timescale 1ns/10ps
`include "stq_consts.svh"

module stq_top (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  // Dispatch
  input  logic                        i_disp_valid,
  input  stq_core_pkg::disp_t         i_disp,
  output logic                        o_disp_ready,
  output stq_core_pkg::stq_idx_t      o_disp_idx,

  // LSU pipeline
  input  logic                        i_ex1_valid,
  input  stq_mem_pkg::ex1_upd_t       i_ex1,
  input  logic                        i_data_valid,
  input  stq_mem_pkg::data_wr_t       i_data,

  // Commit and flush
  input  logic                        i_commit_valid,
  input  stq_core_pkg::cmt_id_t       i_commit_cmt_id,
  input  stq_core_pkg::flush_t        i_flush,

  // Store buffer
  output logic                        o_stbuf_req_valid,
  output stq_mem_pkg::stbuf_req_t     o_stbuf_req,
  input  logic                        i_stbuf_accept,

  output logic                        o_empty
);

  logic [`STQ_ENTRIES-1:0]   w_load;
  stq_core_pkg::disp_t       w_disp;
  stq_mem_pkg::stq_entry_t   w_entries [`STQ_ENTRIES];
  logic [`STQ_ENTRIES-1:0]   w_req_valid;
  logic [`STQ_ENTRIES-1:0]   w_finish;
  logic [`STQ_ENTRIES-1:0]   w_outptr;
  logic [`STQ_ENTRIES-1:0]   w_accept;
  stq_core_pkg::stq_idx_t    w_head;
  logic                      w_retire;

  stq_alloc alloc_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_disp       (i_disp),
    .i_head       (w_head),
    .i_retire     (w_retire),
    .o_disp_ready (o_disp_ready),
    .o_disp_idx   (o_disp_idx),
    .o_load       (w_load),
    .o_disp       (w_disp),
    .o_empty      (o_empty)
  );

  for (genvar g = 0; g < `STQ_ENTRIES; g++) begin : g_entry
    stq_entry #(.entry_index(g)) entry_i (
      .i_clk           (i_clk),
      .i_reset_n       (i_reset_n),
      .i_load          (w_load[g]),
      .i_disp          (w_disp),
      .i_flush_at_disp (i_flush.valid),
      .i_ex1_valid     (i_ex1_valid),
      .i_ex1           (i_ex1),
      .i_data_valid    (i_data_valid),
      .i_data          (i_data),
      .i_commit_valid  (i_commit_valid),
      .i_commit_cmt_id (i_commit_cmt_id),
      .i_flush         (i_flush),
      .i_outptr_valid  (w_outptr[g]),
      .i_stbuf_accept  (w_accept[g]),
      .o_entry         (w_entries[g]),
      .o_req_valid     (w_req_valid[g]),
      .o_finish        (w_finish[g])
    );
  end

  stq_drain drain_i (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_entries         (w_entries),
    .i_req_valid       (w_req_valid),
    .i_finish          (w_finish),
    .i_stbuf_accept    (i_stbuf_accept),
    .o_outptr          (w_outptr),
    .o_accept          (w_accept),
    .o_head            (w_head),
    .o_retire          (w_retire),
    .o_stbuf_req_valid (o_stbuf_req_valid),
    .o_stbuf_req       (o_stbuf_req)
  );

endmodule
